/* rtl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// one machine word, used for data and for instructions
`define CPU_DATA_W 16

// register index width, sixteen registers
`define CPU_REG_AW 4

// instruction memory word address, 256 words
`define IMEM_AW 8

// data memory word address, 256 words
`define DMEM_AW 8

`endif

/* rtl/cpu_pkg.sv */
package cpu_pkg;

  // top nibble of every instruction
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    XOR = 4'd2,
    AND = 4'd3,
    SLL = 4'd4,
    SRA = 4'd5,
    ROR = 4'd6,
    OR  = 4'd7,
    LW  = 4'd8,
    SW  = 4'd9,
    LLB = 4'd10,
    LHB = 4'd11,
    B   = 4'd12,
    BR  = 4'd13,
    PCS = 4'd14,
    HLT = 4'd15
  } opcode_e;

  // branch condition, bits 11:9 of B and BR
  typedef enum logic [2:0] {
    NE = 3'd0,
    EQ = 3'd1,
    GT = 3'd2,
    LT = 3'd3,
    GE = 3'd4,
    LE = 3'd5,
    OV = 3'd6,
    UN = 3'd7
  } cond_e;

  // bit order matches the flag update mask, z on top
  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

endpackage

/* rtl/rf_if.sv */
`include "cpu_defs.svh"

interface rf_if;

  // read and write indices
  logic [`CPU_REG_AW-1:0] src1;
  logic [`CPU_REG_AW-1:0] src2;
  logic [`CPU_REG_AW-1:0] dst;

  // write port, committed at the clock edge
  logic                   we;
  logic [`CPU_DATA_W-1:0] wdata;

  // combinational read data
  logic [`CPU_DATA_W-1:0] rdata1;
  logic [`CPU_DATA_W-1:0] rdata2;

  // decode side picks indices and write-back
  modport decode (
    output src1, src2, dst, we, wdata,
    input  rdata1, rdata2
  );

  // register file side answers the reads
  modport rf (
    input  src1, src2, dst, we, wdata,
    output rdata1, rdata2
  );

endinterface

/* rtl/alu.sv */
`include "cpu_defs.svh"

module alu import cpu_pkg::*; (
  input  opcode_e                op,
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  input  logic [3:0]             imm4,
  input  logic [7:0]             imm8,
  output logic [`CPU_DATA_W-1:0] result,
  output flags_t                 new_flags,
  output logic [2:0]             flag_upd
);

  logic [`CPU_DATA_W-1:0]   sum;
  logic [`CPU_DATA_W-1:0]   diff;
  logic [2*`CPU_DATA_W-1:0] rot;
  logic                     ovf_add;
  logic                     ovf_sub;

  assign sum  = a + b;
  assign diff = a - b;
  // rotate by shifting a doubled copy, low half is the answer
  assign rot  = {a, a} >> imm4;

  // overflow when the sign of the result cannot come from the operands
  assign ovf_add = (a[`CPU_DATA_W-1] == b[`CPU_DATA_W-1]) &&
                   (sum[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
  assign ovf_sub = (a[`CPU_DATA_W-1] != b[`CPU_DATA_W-1]) &&
                   (diff[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);

  always_comb begin
    result   = '0;
    flag_upd = 3'b000;
    case (op)
      ADD: result = sum;
      SUB: result = diff;
      XOR: result = a ^ b;
      AND: result = a & b;
      SLL: result = a << imm4;
      SRA: result = $signed(a) >>> imm4;
      ROR: result = rot[`CPU_DATA_W-1:0];
      OR:  result = a | b;
      // a carries rd for the byte loads
      LLB: result = {a[`CPU_DATA_W-1:8], imm8};
      LHB: result = {imm8, a[7:0]};
      default: result = '0;
    endcase
    // z on every arithmetic and logic op, n and v only on add and sub
    if (op == ADD || op == SUB) begin
      flag_upd = 3'b111;
    end else if (op <= OR) begin
      flag_upd = 3'b100;
    end
  end

  assign new_flags.z = (result == '0);
  assign new_flags.n = result[`CPU_DATA_W-1];
  assign new_flags.v = (op == ADD) ? ovf_add : (op == SUB) ? ovf_sub : 1'b0;

endmodule

/* rtl/register_file.sv */
`include "cpu_defs.svh"

module register_file import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  flags_t     new_flags,
  input  logic [2:0] flag_upd,
  rf_if.rf           rf,
  output flags_t     flags
);

  logic [`CPU_DATA_W-1:0] regs [2**`CPU_REG_AW];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**`CPU_REG_AW; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
    end else begin
      // register 0 is never written so it keeps its reset value
      if (rf.we && rf.dst != '0) begin
        regs[rf.dst] <= rf.wdata;
      end
      // each flag loads only when the alu defines it
      if (flag_upd[2]) begin
        flags.z <= new_flags.z;
      end
      if (flag_upd[1]) begin
        flags.n <= new_flags.n;
      end
      if (flag_upd[0]) begin
        flags.v <= new_flags.v;
      end
    end
  end

  // plain array reads, zero comes from reset plus the write guard
  assign rf.rdata1 = regs[rf.src1];
  assign rf.rdata2 = regs[rf.src2];

  a_reg0_zero: assert property (
    @(posedge clk) disable iff (rst)
    (rf.src1 == '0 |-> rf.rdata1 == '0) and (rf.src2 == '0 |-> rf.rdata2 == '0)
  ) else $error("register_file: register 0 read nonzero");

endmodule

/* rtl/pc_control.sv */
`include "cpu_defs.svh"

module pc_control import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`CPU_DATA_W-1:0] instr,
  input  flags_t                 flags,
  input  logic [`CPU_DATA_W-1:0] rs_data,
  output logic [`CPU_DATA_W-1:0] pc
);

  opcode_e                op;
  cond_e                  cond;
  logic                   taken;
  logic [`CPU_DATA_W-1:0] pc_plus2;
  logic [`CPU_DATA_W-1:0] br_target;
  logic [`CPU_DATA_W-1:0] pc_next;

  assign op   = opcode_e'(instr[15:12]);
  assign cond = cond_e'(instr[11:9]);

  assign pc_plus2 = pc + `CPU_DATA_W'(2);
  // signed 9-bit word offset, counted from the next instruction
  assign br_target = pc_plus2 + {{(`CPU_DATA_W-10){instr[8]}}, instr[8:0], 1'b0};

  // condition test against the stored flags only
  always_comb begin
    case (cond)
      NE: taken = !flags.z;
      EQ: taken = flags.z;
      GT: taken = !flags.z && !flags.n;
      LT: taken = flags.n;
      GE: taken = flags.z || !flags.n;
      LE: taken = flags.z || flags.n;
      OV: taken = flags.v;
      default: taken = 1'b1;
    endcase
  end

  always_comb begin
    case (op)
      B:       pc_next = taken ? br_target : pc_plus2;
      BR:      pc_next = taken ? rs_data : pc_plus2;
      // halt parks the fetch on itself
      HLT:     pc_next = pc;
      default: pc_next = pc_plus2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // an odd register value on BR would break word fetch
  a_pc_even: assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
    else $error("pc_control: odd pc %h", pc);

endmodule

/* rtl/instr_mem.sv */
`include "cpu_defs.svh"

module instr_mem (
  input  logic                   clk,
  input  logic                   prog_we,
  input  logic [`IMEM_AW-1:0]    prog_addr,
  input  logic [`CPU_DATA_W-1:0] prog_data,
  input  logic [`CPU_DATA_W-1:0] pc,
  output logic [`CPU_DATA_W-1:0] instr
);

  logic [`CPU_DATA_W-1:0] mem [2**`IMEM_AW];

  // program words arrive through the load port during reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // byte address from pc, drop bit 0 for the word index
  assign instr = mem[pc[`IMEM_AW:1]];

endmodule

/* rtl/data_mem.sv */
`include "cpu_defs.svh"

module data_mem import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  opcode_e                op,
  input  logic [`CPU_DATA_W-1:0] base,
  input  logic [3:0]             offset,
  input  logic [`CPU_DATA_W-1:0] wdata,
  output logic [`CPU_DATA_W-1:0] rdata
);

  logic [`CPU_DATA_W-1:0] mem [2**`DMEM_AW];
  logic [`CPU_DATA_W-1:0] addr;
  logic [`DMEM_AW-1:0]    word;

  // rs plus sign-extended imm4, scaled to bytes
  assign addr = base + {{(`CPU_DATA_W-5){offset[3]}}, offset, 1'b0};
  assign word = addr[`DMEM_AW:1];

  always_ff @(posedge clk) begin
    if (rst) begin
      // clear wins over any store seen while loading
      for (int i = 0; i < 2**`DMEM_AW; i++) begin
        mem[i] <= '0;
      end
    end else if (op == SW) begin
      mem[word] <= wdata;
    end
  end

  assign rdata = mem[word];

endmodule

/* rtl/cpu.sv */
`include "cpu_defs.svh"

module cpu import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   prog_we,
  input  logic [`IMEM_AW-1:0]    prog_addr,
  input  logic [`CPU_DATA_W-1:0] prog_data,
  output logic [`CPU_DATA_W-1:0] pc,
  output logic                   hlt,
  output logic                   wb_en,
  output logic [`CPU_REG_AW-1:0] wb_reg,
  output logic [`CPU_DATA_W-1:0] wb_data
);

  logic [`CPU_DATA_W-1:0] instr;
  opcode_e                op;
  logic [`CPU_REG_AW-1:0] rd;
  logic [`CPU_REG_AW-1:0] rs;
  logic [`CPU_REG_AW-1:0] rt;
  logic                   reg_write;
  logic [`CPU_DATA_W-1:0] alu_result;
  logic [`CPU_DATA_W-1:0] mem_rdata;
  logic [`CPU_DATA_W-1:0] pc_plus2;
  flags_t                 new_flags;
  flags_t                 flags;
  logic [2:0]             flag_upd;

  rf_if rf_bus ();

  // instruction fields
  assign op = opcode_e'(instr[15:12]);
  assign rd = instr[11:8];
  assign rs = instr[7:4];
  assign rt = instr[3:0];

  assign hlt      = (op == HLT);
  assign pc_plus2 = pc + `CPU_DATA_W'(2);

  // byte loads modify rd in place, stores take their data from rd
  assign rf_bus.src1 = (op == LLB || op == LHB) ? rd : rs;
  assign rf_bus.src2 = (op == SW) ? rd : rt;
  assign rf_bus.dst  = rd;

  always_comb begin
    case (op)
      ADD, SUB, XOR, AND, SLL, SRA, ROR, OR,
      LW, LLB, LHB, PCS: reg_write = 1'b1;
      default:           reg_write = 1'b0;
    endcase
  end

  // no retirement while the program is loading
  assign rf_bus.we = reg_write && !rst;

  // write-back mux
  assign rf_bus.wdata = (op == LW)  ? mem_rdata :
                        (op == PCS) ? pc_plus2  : alu_result;

  // trace taps the register-file write port
  assign wb_en   = rf_bus.we;
  assign wb_reg  = rf_bus.dst;
  assign wb_data = rf_bus.wdata;

  instr_mem i_instr_mem (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .instr     (instr)
  );

  pc_control i_pc_control (
    .clk     (clk),
    .rst     (rst),
    .instr   (instr),
    .flags   (flags),
    .rs_data (rf_bus.rdata1),
    .pc      (pc)
  );

  register_file i_register_file (
    .clk       (clk),
    .rst       (rst),
    .new_flags (new_flags),
    .flag_upd  (flag_upd),
    .rf        (rf_bus.rf),
    .flags     (flags)
  );

  alu i_alu (
    .op        (op),
    .a         (rf_bus.rdata1),
    .b         (rf_bus.rdata2),
    .imm4      (instr[3:0]),
    .imm8      (instr[7:0]),
    .result    (alu_result),
    .new_flags (new_flags),
    .flag_upd  (flag_upd)
  );

  // base from rs, store data from rd
  data_mem i_data_mem (
    .clk    (clk),
    .rst    (rst),
    .op     (op),
    .base   (rf_bus.rdata1),
    .offset (instr[3:0]),
    .wdata  (rf_bus.rdata2),
    .rdata  (mem_rdata)
  );

endmodule

/* verification/cpu_checker.sv */
`include "cpu_defs.svh"

module cpu_checker import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   prog_we,
  input  logic [`IMEM_AW-1:0]    prog_addr,
  input  logic [`CPU_DATA_W-1:0] prog_data,
  input  logic [`CPU_DATA_W-1:0] pc,
  input  logic                   hlt,
  input  logic                   wb_en,
  input  logic [`CPU_REG_AW-1:0] wb_reg,
  input  logic [`CPU_DATA_W-1:0] wb_data,
  output int                     errors,
  output int                     retired,
  output logic                   halted
);
  timeunit 1ns;
  timeprecision 100ps;

  // architectural state of the reference model
  logic [15:0] imem [2**`IMEM_AW];
  logic [15:0] dmem [2**`DMEM_AW];
  logic [15:0] regs [16];
  logic [15:0] mpc;
  logic        fz;
  logic        fn;
  logic        fv;

  // private copy of the program, taken from the load port
  always @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  function automatic logic cond_met(input cond_e c);
    case (c)
      NE: return !fz;
      EQ: return fz;
      GT: return !fz && !fn;
      LT: return fn;
      GE: return fz || !fn;
      LE: return fz || fn;
      OV: return fv;
      default: return 1'b1;
    endcase
  endfunction

  task automatic report_mismatch(input string what, input logic [15:0] got, input logic [15:0] exp);
    errors++;
    $display("ERROR @ %0t: %s got %h expected %h", $time, what, got, exp);
  endtask

  // one instruction of the model, checked against the DUT before its commit edge
  task automatic step_model();
    logic [15:0] ins;
    opcode_e     op;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [3:0]  rt;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] addr;
    logic [15:0] next_pc;
    logic [31:0] rot;
    logic        we;
    int          wide;
    ins = imem[mpc[8:1]];
    op  = opcode_e'(ins[15:12]);
    rd  = ins[11:8];
    rs  = ins[7:4];
    rt  = ins[3:0];
    // byte loads merge into the old rd value
    a       = (op == LLB || op == LHB) ? regs[rd] : regs[rs];
    b       = regs[rt];
    addr    = regs[rs] + {{11{rt[3]}}, rt, 1'b0};
    res     = '0;
    we      = 1'b1;
    next_pc = mpc + 16'd2;
    case (op)
      ADD: begin
        res  = a + b;
        wide = $signed(a) + $signed(b);
        fn   = res[15];
        fv   = (wide > 32767) || (wide < -32768);
      end
      SUB: begin
        res  = a - b;
        wide = $signed(a) - $signed(b);
        fn   = res[15];
        fv   = (wide > 32767) || (wide < -32768);
      end
      XOR: res = a ^ b;
      AND: res = a & b;
      OR:  res = a | b;
      SLL: res = a << rt;
      SRA: res = $signed(a) >>> rt;
      ROR: begin
        rot = {16'd0, a};
        rot = (rot >> rt) | (rot << (16 - rt));
        res = rot[15:0];
      end
      LW:  res = dmem[addr[8:1]];
      SW: begin
        we = 1'b0;
        dmem[addr[8:1]] = regs[rd];
      end
      LLB: res = {a[15:8], ins[7:0]};
      LHB: res = {ins[7:0], a[7:0]};
      B: begin
        we = 1'b0;
        if (cond_met(cond_e'(ins[11:9]))) begin
          next_pc = next_pc + {{6{ins[8]}}, ins[8:0], 1'b0};
        end
      end
      BR: begin
        we = 1'b0;
        if (cond_met(cond_e'(ins[11:9]))) begin
          next_pc = regs[rs];
        end
      end
      PCS: res = mpc + 16'd2;
      default: begin
        // halt parks on itself
        we      = 1'b0;
        next_pc = mpc;
      end
    endcase
    if (op <= OR) begin
      fz = (res == '0);
    end
    if (pc !== mpc) begin
      report_mismatch("pc", pc, mpc);
    end
    if (hlt !== (op == HLT)) begin
      report_mismatch("hlt", {15'd0, hlt}, {15'd0, op == HLT});
    end
    if (wb_en !== we) begin
      report_mismatch("wb_en", {15'd0, wb_en}, {15'd0, we});
    end else if (we && wb_reg !== rd) begin
      report_mismatch("wb_reg", {12'd0, wb_reg}, {12'd0, rd});
    end else if (we && wb_data !== res) begin
      report_mismatch("wb_data", wb_data, res);
    end
    // register 0 keeps zero whatever is written
    if (we && rd != '0) begin
      regs[rd] = res;
    end
    if (op == HLT) begin
      halted = 1'b1;
    end else begin
      retired++;
    end
    mpc = next_pc;
  endtask

  // mid-cycle sampling, away from the edge and the 1 ns input updates
  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] = '0;
      end
      for (int i = 0; i < 2**`DMEM_AW; i++) begin
        dmem[i] = '0;
      end
      {fz, fn, fv} = 3'b000;
      mpc    = '0;
      halted = 1'b0;
      if (wb_en !== 1'b0) begin
        report_mismatch("wb_en in reset", {15'd0, wb_en}, 16'd0);
      end
    end else begin
      step_model();
    end
  end

endmodule

/* verification/cpu_tb.sv */
`include "cpu_defs.svh"

module cpu_tb import cpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAND_LEN    = 200;
  localparam int FRAG_CNT    = 4;
  localparam int PROG_LEN    = RAND_LEN + 5 * FRAG_CNT + 1;
  localparam int RESET_TAIL  = 10;
  // one cycle per program word, then the reset tail
  localparam int LOAD_CYCLES = PROG_LEN + RESET_TAIL + 1;
  localparam int MAX_CYCLES  = 2 * PROG_LEN + LOAD_CYCLES + 100;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   prog_we;
  logic [`IMEM_AW-1:0]    prog_addr;
  logic [`CPU_DATA_W-1:0] prog_data;
  logic [`CPU_DATA_W-1:0] pc;
  logic                   hlt;
  logic                   wb_en;
  logic [`CPU_REG_AW-1:0] wb_reg;
  logic [`CPU_DATA_W-1:0] wb_data;
  int                     errors;
  int                     retired;
  int                     cycles;
  logic                   halted;
  logic [15:0]            prog [PROG_LEN];

  always #10 clk = ~clk;

  cpu i_cpu (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .hlt       (hlt),
    .wb_en     (wb_en),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data)
  );

  cpu_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .hlt       (hlt),
    .wb_en     (wb_en),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .errors    (errors),
    .retired   (retired),
    .halted    (halted)
  );

  // any opcode but BR and HLT, branches only forward inside the random part
  function automatic logic [15:0] random_instr(input int idx);
    logic [3:0]  op;
    logic [15:0] ins;
    int          max_off;
    op = 4'($urandom_range(13, 0));
    if (op == 4'd13) begin
      op = PCS;
    end
    case (op)
      LW, SW: begin
        // base r0 half the time, so loads often hit earlier stores
        ins = {op, 4'($urandom), ($urandom_range(1, 0) != 0) ? 4'd0 : 4'($urandom),
               4'($urandom)};
      end
      B: begin
        max_off = RAND_LEN - 1 - idx;
        if (max_off > 7) begin
          max_off = 7;
        end
        ins = {B, 3'($urandom), 9'($urandom_range(max_off, 0))};
      end
      default: ins = {op, 12'($urandom)};
    endcase
    return ins;
  endfunction

  task automatic build_program();
    int          j;
    logic [15:0] target;
    for (int i = 0; i < RAND_LEN; i++) begin
      prog[i] = random_instr(i);
    end
    // r13 gets the BR target byte by byte, the word after BR is skipped when taken
    for (int f = 0; f < FRAG_CNT; f++) begin
      j           = RAND_LEN + 5 * f;
      target      = 16'((j + 4) * 2);
      prog[j]     = {LLB, 4'd13, target[7:0]};
      prog[j + 1] = {LHB, 4'd13, target[15:8]};
      prog[j + 2] = {BR, (f == 0) ? UN : cond_e'($urandom), 1'b0, 4'd13, 4'd0};
      prog[j + 3] = {LLB, 4'd12, 8'($urandom)};
      prog[j + 4] = {PCS, 4'($urandom_range(15, 1)), 8'd0};
    end
    prog[PROG_LEN - 1] = {HLT, 12'd0};
  endtask

  task automatic report_results(input logic timed_out);
    $display("errors: %0d, instructions retired: %0d", errors, retired);
    if (errors == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: program never halted within %0d cycles", MAX_CYCLES);
      report_results(1'b1);
    end
  end

  initial begin
    rst       = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    void'($urandom(32'hff9b));
    build_program();
    // word 0 is on the port before the first edge
    prog_we   = 1'b1;
    prog_data = prog[0];
    for (int i = 1; i < PROG_LEN; i++) begin
      @(posedge clk);
      #1;
      prog_addr = `IMEM_AW'(i);
      prog_data = prog[i];
    end
    @(posedge clk);
    #1;
    prog_we = 1'b0;
    repeat (RESET_TAIL) @(posedge clk);
    #1;
    rst = 1'b0;
    wait (halted === 1'b1);
    // pc must stay on the halt for a few more cycles
    repeat (5) @(posedge clk);
    report_results(1'b0);
  end

endmodule

/* vlog.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/rf_if.sv
rtl/alu.sv
rtl/register_file.sv
rtl/pc_control.sv
rtl/instr_mem.sv
rtl/data_mem.sv
rtl/cpu.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/rf_if.sv
      - rtl/alu.sv
      - rtl/register_file.sv
      - rtl/pc_control.sv
      - rtl/instr_mem.sv
      - rtl/data_mem.sv
      - rtl/cpu.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/cpu_checker.sv
      - verification/cpu_tb.sv
